/* verilog/attack_pkg.sv */
package attack_pkg;

	// turn number, picks one of four patterns
	typedef logic [1:0] turn_t;

	// 0 up, 1 right, 2 down, 3 left
	typedef logic [1:0] dir_t;

	// distance units per frame
	typedef logic [2:0] speed_t;

	// launch gap in launch periods
	typedef logic [2:0] gap_t;

	// distance left to the player
	typedef logic [7:0] dist_t;

	// arrow position within a pattern
	typedef logic [3:0] idx_t;

	// arrow counts per phase
	typedef logic [3:0] count_t;

	// entry distance of every arrow
	localparam dist_t START_DIST = 8'd200;

	// longest pattern in the table
	localparam int MAX_ARROWS = 8;

endpackage

/* verilog/launch_timer.sv */
`timescale 1ns/1ps

module launch_timer #(
	parameter int LAUNCH_UNIT = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             gap_start,
	input  attack_pkg::gap_t gap,
	output logic             gap_done
);
	// gap is at most 7, so 8 units always fit the target
	localparam int CW = $clog2(8 * LAUNCH_UNIT);

	logic [CW-1:0] target;
	logic [CW-1:0] elapsed;
	logic          running;

	assign gap_done = running && (elapsed >= target);

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
		end else if (gap_start) begin
			running <= 1'b1;
		end else if (gap_done) begin
			running <= 1'b0;
		end
	end

	// elapsed counts cycles since gap_start
	always_ff @(posedge clk) begin
		if (gap_start) begin
			target  <= CW'(gap) * CW'(LAUNCH_UNIT);
			elapsed <= CW'(1);
		end else if (running) begin
			elapsed <= elapsed + 1'b1;
		end
	end

endmodule

/* verilog/pattern_rom.sv */
`timescale 1ns/1ps

module pattern_rom (
	input  attack_pkg::turn_t  turn,
	input  attack_pkg::idx_t   arrow_idx,
	output attack_pkg::count_t count,
	output attack_pkg::gap_t   gap,
	output attack_pkg::speed_t speed,
	output attack_pkg::dir_t   dir
);
	import attack_pkg::*;

	// two bits per arrow, arrow 0 in the low bits
	logic [2*MAX_ARROWS-1:0] dir_list;
	gap_t                    row_gap;
	speed_t                  row_speed;

	always_comb begin
		case (turn)
			2'd0: begin
				count     = count_t'(6);
				row_gap   = gap_t'(1);
				row_speed = speed_t'(4);
				dir_list  = {2'd0, 2'd0, 2'd1, 2'd0, 2'd3, 2'd2, 2'd1, 2'd0};
			end
			2'd1: begin
				count     = count_t'(8);
				row_gap   = gap_t'(2);
				row_speed = speed_t'(2);
				dir_list  = {2'd1, 2'd3, 2'd1, 2'd3, 2'd0, 2'd0, 2'd2, 2'd2};
			end
			2'd2: begin
				count     = count_t'(5);
				row_gap   = gap_t'(1);
				row_speed = speed_t'(7);
				dir_list  = {2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd3, 2'd3, 2'd3};
			end
			default: begin
				// pattern 3 alternates on odd and even arrows
				count     = count_t'(7);
				row_gap   = arrow_idx[0] ? gap_t'(3) : gap_t'(1);
				row_speed = arrow_idx[0] ? speed_t'(5) : speed_t'(3);
				dir_list  = {2'd0, 2'd1, 2'd2, 2'd0, 2'd3, 2'd1, 2'd2, 2'd0};
			end
		endcase

		if (count_t'(arrow_idx) < count) begin
			gap   = row_gap;
			speed = row_speed;
			dir   = dir_list[2*arrow_idx +: 2];
		end else begin
			gap   = '0;
			speed = '0;
			dir   = '0;
		end
	end

endmodule

/* verilog/arrow_field.sv */
`timescale 1ns/1ps

module arrow_field #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 phase_clear,
	input  logic                 launch,
	input  attack_pkg::speed_t   speed,
	input  attack_pkg::dir_t     dir,
	input  attack_pkg::dir_t     shield,
	input  logic                 frame_tick,
	output logic                 lane_free,
	output logic [NUM_LANES-1:0] blocked,
	output logic [NUM_LANES-1:0] struck
);
	import attack_pkg::*;

	localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [NUM_LANES-1:0] lane_valid;
	dist_t                lane_dist [NUM_LANES];
	speed_t               lane_speed [NUM_LANES];
	dir_t                 lane_dir [NUM_LANES];
	logic [LW-1:0]        next_lane;
	logic [LW-1:0]        sel_lane;
	logic [NUM_LANES-1:0] arrive;

	assign lane_free = ~&lane_valid;

	// first free lane at or after the pointer, wrapping around
	always_comb begin : pick_lane
		int   idx;
		logic found;
		sel_lane = next_lane;
		found = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			idx = (int'(next_lane) + i) % NUM_LANES;
			if (!found && !lane_valid[idx]) begin
				sel_lane = LW'(idx);
				found = 1'b1;
			end
		end
	end

	// arrival when this frame's step would take the distance to zero or below
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			arrive[i]  = frame_tick && lane_valid[i] && (lane_dist[i] <= dist_t'(lane_speed[i]));
			blocked[i] = arrive[i] && (lane_dir[i] == shield);
			struck[i]  = arrive[i] && (lane_dir[i] != shield);
		end
	end

	always_ff @(posedge clk) begin
		if (rst || phase_clear) begin
			lane_valid <= '0;
			next_lane  <= '0;
		end else begin
			for (int i = 0; i < NUM_LANES; i++) begin
				if (launch && sel_lane == LW'(i))
					lane_valid[i] <= 1'b1;
				else if (arrive[i])
					lane_valid[i] <= 1'b0;
			end
			if (launch)
				next_lane <= (sel_lane == LW'(NUM_LANES - 1)) ? '0 : sel_lane + 1'b1;
		end
	end

	// lane contents, only meaningful while the lane is valid
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_LANES; i++) begin
			if (launch && sel_lane == LW'(i)) begin
				lane_dist[i]  <= START_DIST;
				lane_speed[i] <= speed;
				lane_dir[i]   <= dir;
			end else if (frame_tick && lane_valid[i]) begin
				lane_dist[i] <= lane_dist[i] - dist_t'(lane_speed[i]);
			end
		end
	end

endmodule

/* verilog/hit_tally.sv */
`timescale 1ns/1ps

module hit_tally #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 phase_clear,
	input  logic [NUM_LANES-1:0] blocked,
	input  logic [NUM_LANES-1:0] struck,
	output attack_pkg::count_t   resolved,
	output attack_pkg::count_t   hits,
	output attack_pkg::count_t   blocks,
	output logic                 damage
);
	import attack_pkg::*;

	function automatic count_t ones(input logic [NUM_LANES-1:0] v);
		count_t n;
		n = '0;
		for (int i = 0; i < NUM_LANES; i++)
			n = n + count_t'(v[i]);
		return n;
	endfunction

	count_t n_blocked;
	count_t n_struck;

	assign n_blocked = ones(blocked);
	assign n_struck  = ones(struck);

	always_ff @(posedge clk) begin
		if (rst || phase_clear) begin
			resolved <= '0;
			hits     <= '0;
			blocks   <= '0;
		end else begin
			resolved <= resolved + n_blocked + n_struck;
			hits     <= hits + n_struck;
			blocks   <= blocks + n_blocked;
		end
	end

	// one pulse per frame with any arrow getting through
	always_ff @(posedge clk) begin
		if (rst)
			damage <= 1'b0;
		else
			damage <= |struck;
	end

endmodule

/* verilog/attack_phase_fsm.sv */
`timescale 1ns/1ps

module attack_phase_fsm (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	output logic               ack,
	output logic               busy,
	input  attack_pkg::turn_t  turn,
	output attack_pkg::turn_t  phase_turn,
	output attack_pkg::idx_t   arrow_idx,
	input  attack_pkg::count_t count,
	input  attack_pkg::gap_t   gap,
	output logic               gap_start,
	input  logic               gap_done,
	input  logic               lane_free,
	output logic               launch,
	input  attack_pkg::count_t resolved,
	output logic               phase_clear
);
	import attack_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_GAP,
		WAIT_LANE,
		DRAIN,
		DONE
	} state_t;

	state_t state;
	logic   gap_armed;
	logic   last_arrow;

	// the arrow being launched now is the final one of the pattern
	assign last_arrow = (count_t'(arrow_idx) + count_t'(1)) == count;

	// timer starts once per arrow on the first cycle of WAIT_GAP
	assign gap_start = (state == WAIT_GAP) && !gap_armed;
	assign launch = (state == WAIT_LANE) && lane_free;

	always_ff @(posedge clk) begin
		if (state == IDLE && req)
			phase_turn <= turn;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= IDLE;
			busy        <= 1'b0;
			ack         <= 1'b0;
			phase_clear <= 1'b0;
			gap_armed   <= 1'b0;
			arrow_idx   <= '0;
		end else begin
			phase_clear <= 1'b0;
			case (state)
				IDLE: begin
					if (req) begin
						state       <= WAIT_GAP;
						busy        <= 1'b1;
						phase_clear <= 1'b1;
						gap_armed   <= 1'b0;
						arrow_idx   <= '0;
					end
				end
				WAIT_GAP: begin
					gap_armed <= 1'b1;
					if (gap_done)
						state <= WAIT_LANE;
				end
				WAIT_LANE: begin
					// launch waits while all lanes are taken
					if (lane_free) begin
						arrow_idx <= arrow_idx + 1'b1;
						gap_armed <= 1'b0;
						state     <= last_arrow ? DRAIN : WAIT_GAP;
					end
				end
				DRAIN: begin
					if (resolved == count) begin
						state <= DONE;
						busy  <= 1'b0;
						ack   <= 1'b1;
					end
				end
				DONE: begin
					if (!req) begin
						state <= IDLE;
						ack   <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* verilog/attack_top.sv */
`timescale 1ns/1ps

module attack_top #(
	parameter int NUM_LANES = 4,
	parameter int LAUNCH_UNIT = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               req,
	output logic               ack,
	output logic               busy,
	input  attack_pkg::turn_t  turn,
	input  attack_pkg::dir_t   shield,
	input  logic               frame_tick,
	output logic               damage,
	output attack_pkg::count_t hits,
	output attack_pkg::count_t blocks
);
	import attack_pkg::*;

	turn_t                phase_turn;
	idx_t                 arrow_idx;
	count_t               count;
	gap_t                 gap;
	speed_t               speed;
	dir_t                 dir;
	logic                 gap_start;
	logic                 gap_done;
	logic                 lane_free;
	logic                 launch;
	logic                 phase_clear;
	logic [NUM_LANES-1:0] blocked;
	logic [NUM_LANES-1:0] struck;
	count_t               resolved;

	attack_phase_fsm fsm_i (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.ack         (ack),
		.busy        (busy),
		.turn        (turn),
		.phase_turn  (phase_turn),
		.arrow_idx   (arrow_idx),
		.count       (count),
		.gap         (gap),
		.gap_start   (gap_start),
		.gap_done    (gap_done),
		.lane_free   (lane_free),
		.launch      (launch),
		.resolved    (resolved),
		.phase_clear (phase_clear)
	);

	launch_timer #(
		.LAUNCH_UNIT (LAUNCH_UNIT)
	) timer_i (
		.clk       (clk),
		.rst       (rst),
		.gap_start (gap_start),
		.gap       (gap),
		.gap_done  (gap_done)
	);

	// pattern lookup follows the turn latched at phase start
	pattern_rom rom_i (
		.turn      (phase_turn),
		.arrow_idx (arrow_idx),
		.count     (count),
		.gap       (gap),
		.speed     (speed),
		.dir       (dir)
	);

	arrow_field #(
		.NUM_LANES (NUM_LANES)
	) field_i (
		.clk         (clk),
		.rst         (rst),
		.phase_clear (phase_clear),
		.launch      (launch),
		.speed       (speed),
		.dir         (dir),
		.shield      (shield),
		.frame_tick  (frame_tick),
		.lane_free   (lane_free),
		.blocked     (blocked),
		.struck      (struck)
	);

	hit_tally #(
		.NUM_LANES (NUM_LANES)
	) tally_i (
		.clk         (clk),
		.rst         (rst),
		.phase_clear (phase_clear),
		.blocked     (blocked),
		.struck      (struck),
		.resolved    (resolved),
		.hits        (hits),
		.blocks      (blocks),
		.damage      (damage)
	);

endmodule

/* bench/attack_model.svh */
`ifndef ATTACK_MODEL_SVH
`define ATTACK_MODEL_SVH

// arrows in each of the four patterns
function automatic int pattern_count(input int t);
	case (t)
		0: return 6;
		1: return 8;
		2: return 5;
		default: return 7;
	endcase
endfunction

// direction of arrow k in pattern t, 0 up, 1 right, 2 down, 3 left
function automatic int pattern_dir(input int t, input int k);
	int d [8];
	case (t)
		0: d = '{0, 1, 2, 3, 0, 1, 0, 0};
		1: d = '{2, 2, 0, 0, 3, 1, 3, 1};
		2: d = '{3, 3, 3, 1, 1, 0, 0, 0};
		default: d = '{0, 2, 1, 3, 0, 2, 1, 0};
	endcase
	if (k < 0 || k >= pattern_count(t))
		return 0;
	return d[k];
endfunction

// arrows facing the shield get blocked
function automatic int predict_blocks(input int t, input int sh);
	int n;
	n = 0;
	for (int k = 0; k < pattern_count(t); k++) begin
		if (pattern_dir(t, k) == sh)
			n++;
	end
	return n;
endfunction

// everything else reaches the player
function automatic int predict_hits(input int t, input int sh);
	return pattern_count(t) - predict_blocks(t, sh);
endfunction

`endif

/* bench/attack_tb.sv */
`timescale 1ns/1ps

module attack_tb;
	import attack_pkg::*;

	`include "attack_model.svh"

	localparam int NUM_LANES = 4;
	localparam int LAUNCH_UNIT = 8;
	localparam int NUM_PHASES = 20;
	// slowest arrow at one tick in eight over two lane waves, doubled
	localparam int DRAIN_CYCLES = 2 * 2 * (200 / 2) * 8 + MAX_ARROWS * 7 * LAUNCH_UNIT;
	localparam int WATCHDOG_CYCLES = NUM_PHASES * DRAIN_CYCLES;

	logic   clk;
	logic   rst;
	logic   req;
	logic   ack;
	logic   busy;
	turn_t  turn;
	dir_t   shield;
	logic   frame_tick;
	logic   damage;
	count_t hits;
	count_t blocks;

	logic [15:0] lfsr;
	logic        sparse;
	turn_t       sched_turn [NUM_PHASES];
	dir_t        sched_shield [NUM_PHASES];
	logic        sched_sparse [NUM_PHASES];
	int          n_phases;

	attack_top #(
		.NUM_LANES   (NUM_LANES),
		.LAUNCH_UNIT (LAUNCH_UNIT)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.ack        (ack),
		.busy       (busy),
		.turn       (turn),
		.shield     (shield),
		.frame_tick (frame_tick),
		.damage     (damage),
		.hits       (hits),
		.blocks     (blocks)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// x^16 + x^15 + x^13 + x^4 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[14] ^ s[12] ^ s[3];
		return {s[14:0], fb};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("ERR %0t: %s", $time, msg);
			$display("TEST FAIL");
			$fatal(1, "stopped at first error");
		end
	endtask

	// frame ticks about one cycle in four or one in eight when sparse
	initial begin
		frame_tick = 1'b0;
		forever begin
			@(negedge clk);
			if (sparse)
				frame_tick <= (rand_bits(3) == 8'd0);
			else
				frame_tick <= (rand_bits(2) == 8'd0);
		end
	end

	// starts on a falling edge and ends on the falling edge after ack drops
	task automatic run_phase(input turn_t t, input dir_t sh);
		int exp_hits;
		int exp_blocks;
		int pulses;
		exp_hits = predict_hits(int'(t), int'(sh));
		exp_blocks = predict_blocks(int'(t), int'(sh));
		pulses = 0;
		check(busy === 1'b0 && ack === 1'b0, "DUT not idle when the request is raised");
		turn = t;
		shield = sh;
		req = 1'b1;
		@(negedge clk);
		check(busy === 1'b1, "busy not high one cycle after req");
		while (ack !== 1'b1) begin
			check(busy === 1'b1, "busy dropped before ack");
			if (damage === 1'b1)
				pulses++;
			@(negedge clk);
		end
		check(busy === 1'b0, "busy still high in the ack cycle");
		check(int'(hits) + int'(blocks) == pattern_count(int'(t)),
			$sformatf("turn %0d resolved %0d arrows, pattern has %0d", t,
				int'(hits) + int'(blocks), pattern_count(int'(t))));
		check(int'(hits) == exp_hits,
			$sformatf("turn %0d shield %0d hits %0d, expected %0d", t, sh, hits, exp_hits));
		check(int'(blocks) == exp_blocks,
			$sformatf("turn %0d shield %0d blocks %0d, expected %0d", t, sh, blocks, exp_blocks));
		check((pulses > 0) == (exp_hits > 0),
			$sformatf("turn %0d shield %0d saw %0d damage pulses with %0d hits expected",
				t, sh, pulses, exp_hits));
		req = 1'b0;
		@(negedge clk);
		check(ack === 1'b0, "ack still high one cycle after req dropped");
		check(busy === 1'b0, "busy high after the handshake closed");
	endtask

	initial begin
		rst = 1'b1;
		req = 1'b0;
		turn = '0;
		shield = '0;
		sparse = 1'b0;
		lfsr = 16'd65241;

		// directed pattern 2 phases with left shield then up shield
		sched_turn[0] = turn_t'(2);
		sched_shield[0] = dir_t'(3);
		sched_sparse[0] = 1'b0;
		sched_turn[1] = turn_t'(2);
		sched_shield[1] = dir_t'(0);
		sched_sparse[1] = 1'b0;
		for (int i = 2; i < 8; i++) begin
			sched_turn[i] = turn_t'(rand_bits(2));
			sched_shield[i] = dir_t'(rand_bits(2));
			sched_sparse[i] = 1'b0;
		end
		// back to back over every turn with slow frames filling all lanes
		for (int i = 8; i < 16; i++) begin
			sched_turn[i] = turn_t'(i % 4);
			sched_shield[i] = dir_t'(rand_bits(2));
			sched_sparse[i] = 1'b1;
		end
		n_phases = 16;

		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check(busy === 1'b0 && ack === 1'b0 && damage === 1'b0,
			"busy, ack or damage not low after reset");
		check(hits == '0 && blocks == '0, "counts not zero after reset");

		for (int i = 0; i < n_phases; i++) begin
			sparse <= sched_sparse[i];
			run_phase(sched_turn[i], sched_shield[i]);
			if (!sched_sparse[i])
				repeat (3) @(negedge clk);
		end

		repeat (2) @(negedge clk);
		$display("TEST PASS");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: no finish after %0d cycles, the DUT seems to hang", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

/* files.f */
+incdir+bench
verilog/attack_pkg.sv
verilog/launch_timer.sv
verilog/pattern_rom.sv
verilog/arrow_field.sv
verilog/hit_tally.sv
verilog/attack_phase_fsm.sv
verilog/attack_top.sv
bench/attack_tb.sv

/* Makefile */
TOP = attack_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f --Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "^TEST PASS$$" run.log

clean:
	rm -rf obj_dir run.log
